// ==== logic/vec_pkg.sv ====
package vec_pkg;

    // vector geometry
    localparam int NUM_ELEM = 8;
    localparam int IDX_W    = 3;            // element index width
    localparam int ELEM_W   = 10;           // operand element, unsigned
    localparam int RES_W    = 32;           // wide enough for 8 x 1023 x 1023

    // bus geometry
    localparam int ADDR_W = 8;
    localparam int DATA_W = 32;

    // register map, byte addresses
    localparam logic [ADDR_W-1:0] REG_CTRL   = 8'h00;  // write-only, op in [2:0]
    localparam logic [ADDR_W-1:0] REG_STATUS = 8'h04;  // {done, busy}
    localparam logic [ADDR_W-1:0] BASE_A     = 8'h40;
    localparam logic [ADDR_W-1:0] BASE_B     = 8'h80;
    localparam logic [ADDR_W-1:0] BASE_RES   = 8'hC0;
    localparam logic [ADDR_W-1:0] REG_SCALAR = 8'hFC;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef enum logic [2:0] {
        OP_READ = 3'd0,   // res[i] = a[i]
        OP_SUM  = 3'd1,   // res[i] = a[i] + b[i]
        OP_AVG  = 3'd2,   // res[i] = (a[i] + b[i]) / 2
        OP_MAN  = 3'd3,   // scalar = sum |a[i] - b[i]|
        OP_DOT  = 3'd4    // scalar = sum a[i] * b[i]
    } vec_op_e;

    typedef struct packed {
        logic [ELEM_W-1:0] a;
        logic [ELEM_W-1:0] b;
    } operand_t;

    typedef struct packed {
        logic              we;
        logic              sel_b;  // 0 writes A, 1 writes B
        logic [IDX_W-1:0]  idx;
        logic [ELEM_W-1:0] data;
    } bank_wr_t;

    typedef struct packed {
        logic             valid;
        logic [IDX_W-1:0] idx;
        vec_op_e          op;
        logic             last;   // final element of the run
    } lane_t;

    typedef struct packed {
        logic             elem_we;
        logic             scalar_we;
        logic [IDX_W-1:0] idx;
        logic [RES_W-1:0] value;
    } res_wr_t;

endpackage

// ==== logic/vec_bank.sv ====
module vec_bank import vec_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  bank_wr_t         bank_wr,
    input  logic [IDX_W-1:0] rd_idx,
    output operand_t         rd_data
);

    // two independent element arrays, read side by side
    logic [ELEM_W-1:0] mem_a [NUM_ELEM];
    logic [ELEM_W-1:0] mem_b [NUM_ELEM];

    // write port, A or B per access
    always_ff @(posedge clk) begin
        if (bank_wr.we) begin
            if (bank_wr.sel_b) begin
                mem_b[bank_wr.idx] <= bank_wr.data;
            end else begin
                mem_a[bank_wr.idx] <= bank_wr.data;
            end
        end
    end

    // paired read, one cycle latency
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_data <= '0;
        end else begin
            rd_data.a <= mem_a[rd_idx];
            rd_data.b <= mem_b[rd_idx];
        end
    end

endmodule

// ==== logic/vec_regs.sv ====
module vec_regs import vec_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    // write address / data / response
    input  logic [ADDR_W-1:0]   awaddr,
    input  logic                awvalid,
    output logic                awready,
    input  logic [DATA_W-1:0]   wdata,
    input  logic [DATA_W/8-1:0] wstrb,    // full-word registers, strobes ignored
    input  logic                wvalid,
    output logic                wready,
    output logic [1:0]          bresp,
    output logic                bvalid,
    input  logic                bready,
    // read address / data
    input  logic [ADDR_W-1:0]   araddr,
    input  logic                arvalid,
    output logic                arready,
    output logic [DATA_W-1:0]   rdata,
    output logic [1:0]          rresp,
    output logic                rvalid,
    input  logic                rready,
    // core side
    output bank_wr_t            bank_wr,
    output logic                start,
    output vec_op_e             op,
    input  logic                busy,
    input  logic                done,
    output logic [IDX_W-1:0]    res_idx,
    output logic                res_scalar_sel,
    input  logic [RES_W-1:0]    res_rdata
);

    typedef enum logic [2:0] {
        RG_NONE, RG_CTRL, RG_STATUS, RG_A, RG_B, RG_RES, RG_SCALAR
    } region_e;

    region_e           wr_rg;
    region_e           rd_rg;
    logic              wr_fire;
    logic              rd_fire;
    logic [DATA_W-1:0] rd_word;
    logic [ELEM_W-1:0] shadow_a [NUM_ELEM];   // readback copy of A
    logic [ELEM_W-1:0] shadow_b [NUM_ELEM];   // readback copy of B

    // map a byte address onto a register region, word aligned only
    function automatic region_e decode(input logic [ADDR_W-1:0] addr);
        region_e rg;
        rg = RG_NONE;
        if (addr[1:0] == 2'b00) begin
            if (addr == REG_CTRL)
                rg = RG_CTRL;
            else if (addr == REG_STATUS)
                rg = RG_STATUS;
            else if (addr == REG_SCALAR)
                rg = RG_SCALAR;
            else if (addr >= BASE_A && addr < BASE_A + 4 * NUM_ELEM)
                rg = RG_A;
            else if (addr >= BASE_B && addr < BASE_B + 4 * NUM_ELEM)
                rg = RG_B;
            else if (addr >= BASE_RES && addr < BASE_RES + 4 * NUM_ELEM)
                rg = RG_RES;
        end
        return rg;
    endfunction

    assign wr_rg   = decode(awaddr);
    assign wr_fire = awready & awvalid & wready & wvalid;

    // write channel: aw and w taken together, then one response
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            bresp   <= RESP_OKAY;
        end else begin
            awready <= awvalid & wvalid & ~awready & ~bvalid;  // single-cycle pulse
            wready  <= awvalid & wvalid & ~awready & ~bvalid;
            if (wr_fire) begin
                bvalid <= 1'b1;
                bresp  <= (wr_rg == RG_NONE) ? RESP_SLVERR : RESP_OKAY;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    // operand writes only while the core is idle
    always_comb begin
        bank_wr       = '0;
        bank_wr.we    = wr_fire & ~busy & ((wr_rg == RG_A) || (wr_rg == RG_B));
        bank_wr.sel_b = (wr_rg == RG_B);
        bank_wr.idx   = awaddr[IDX_W+1:2];
        bank_wr.data  = wdata[ELEM_W-1:0];
    end

    assign start = wr_fire & (wr_rg == RG_CTRL);  // ctrl drops it when busy
    assign op    = vec_op_e'(wdata[2:0]);

    always_ff @(posedge clk) begin
        if (bank_wr.we) begin
            if (bank_wr.sel_b)
                shadow_b[bank_wr.idx] <= bank_wr.data;
            else
                shadow_a[bank_wr.idx] <= bank_wr.data;
        end
    end

    assign rd_rg          = decode(araddr);
    assign rd_fire        = arready & arvalid;
    assign res_idx        = araddr[IDX_W+1:2];     // same slot in every region
    assign res_scalar_sel = (rd_rg == RG_SCALAR);

    always_comb begin
        case (rd_rg)
            RG_STATUS:        rd_word = {{(DATA_W-2){1'b0}}, done, busy};
            RG_A:             rd_word = DATA_W'(shadow_a[res_idx]);  // upper bits zero
            RG_B:             rd_word = DATA_W'(shadow_b[res_idx]);
            RG_RES, RG_SCALAR: rd_word = DATA_W'(res_rdata);
            default:          rd_word = '0;        // ctrl is write-only, unmapped is zero
        endcase
    end

    // read channel
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rdata   <= '0;
            rresp   <= RESP_OKAY;
        end else begin
            arready <= arvalid & ~arready & ~rvalid;
            if (rd_fire) begin
                rvalid <= 1'b1;
                rdata  <= rd_word;
                rresp  <= (rd_rg == RG_NONE) ? RESP_SLVERR : RESP_OKAY;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

endmodule

// ==== logic/vec_ctrl.sv ====
module vec_ctrl import vec_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,
    input  vec_op_e          op,
    output lane_t            issue,
    output logic [IDX_W-1:0] rd_idx,
    output logic             acc_clear,
    input  logic             wb_last,
    output logic             busy,
    output logic             done
);

    typedef enum logic [1:0] {
        ST_IDLE,    // waiting for a start
        ST_ISSUE,   // one element per cycle
        ST_DRAIN    // pipeline emptying
    } state_e;

    state_e           state;
    logic [IDX_W-1:0] cnt;     // next element to issue
    vec_op_e          op_q;    // op held for the whole run
    logic             cnt_last;

    assign cnt_last = (cnt == IDX_W'(NUM_ELEM - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            cnt       <= '0;
            op_q      <= OP_READ;
            acc_clear <= 1'b0;
            done      <= 1'b0;
        end else begin
            acc_clear <= 1'b0;                    // pulse only
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state     <= ST_ISSUE;
                        cnt       <= '0;
                        op_q      <= op;
                        acc_clear <= 1'b1;
                        done      <= 1'b0;        // new run clears done
                    end
                end
                ST_ISSUE: begin
                    cnt <= cnt + 1'b1;
                    if (cnt_last)
                        state <= ST_DRAIN;
                end
                ST_DRAIN: begin
                    if (wb_last) begin            // last element written back
                        state <= ST_IDLE;
                        done  <= 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_comb begin
        issue.valid = (state == ST_ISSUE);
        issue.idx   = cnt;
        issue.op    = op_q;
        issue.last  = cnt_last;
    end

    assign rd_idx = cnt;                  // bank read in step with the lane
    assign busy   = (state != ST_IDLE);

endmodule

// ==== logic/vec_core.sv ====
module vec_core import vec_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  lane_t    issue,
    input  operand_t operands,
    input  logic     acc_clear,
    output res_wr_t  res_wr,
    output logic     wb_last
);

    lane_t               s1_lane;     // lane lined up with bank data
    lane_t               s2_lane;
    logic [RES_W-1:0]    s2_val;      // per-element result
    logic [RES_W-1:0]    calc;
    logic [RES_W-1:0]    acc;         // running man / dot total
    logic [RES_W-1:0]    acc_next;
    logic [ELEM_W:0]     pair_sum;    // one carry bit
    logic [ELEM_W-1:0]   abs_diff;
    logic [2*ELEM_W-1:0] prod;
    logic                s2_scalar;

    // stage 1, fetch-align: the bank answers one cycle after issue
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_lane <= '0;
        end else begin
            s1_lane <= issue;
        end
    end

    // stage 2, compute
    assign pair_sum = {1'b0, operands.a} + {1'b0, operands.b};
    assign abs_diff = (operands.a >= operands.b) ? operands.a - operands.b
                                                 : operands.b - operands.a;
    assign prod     = operands.a * operands.b;

    always_comb begin
        case (s1_lane.op)
            OP_SUM:  calc = RES_W'(pair_sum);
            OP_AVG:  calc = RES_W'(pair_sum[ELEM_W:1]);   // floor of half
            OP_MAN:  calc = RES_W'(abs_diff);
            OP_DOT:  calc = RES_W'(prod);
            default: calc = RES_W'(operands.a);           // read, plain copy of A
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s2_lane <= '0;
        end else begin
            s2_lane <= s1_lane;
        end
    end

    always_ff @(posedge clk) begin
        s2_val <= calc;
    end

    // stage 3, write back or accumulate
    assign s2_scalar = (s2_lane.op == OP_MAN) || (s2_lane.op == OP_DOT);
    assign acc_next  = acc + s2_val;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc     <= '0;
            res_wr  <= '0;
            wb_last <= 1'b0;
        end else begin
            res_wr.elem_we   <= s2_lane.valid & ~s2_scalar;
            res_wr.scalar_we <= s2_lane.valid & s2_scalar & s2_lane.last;  // total at end
            res_wr.idx       <= s2_lane.idx;
            res_wr.value     <= s2_scalar ? acc_next : s2_val;
            wb_last          <= s2_lane.valid & s2_lane.last;
            if (acc_clear)
                acc <= '0;
            else if (s2_lane.valid && s2_scalar)
                acc <= acc_next;
        end
    end

endmodule

// ==== logic/vec_result_mem.sv ====
module vec_result_mem import vec_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  res_wr_t          res_wr,
    input  logic [IDX_W-1:0] rd_idx,
    input  logic             rd_scalar_sel,
    output logic [RES_W-1:0] rd_data
);

    logic [RES_W-1:0] elem_res [NUM_ELEM];   // read / sum / avg results
    logic [RES_W-1:0] scalar_res;            // man / dot result

    // entries keep their value until a run overwrites them
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_ELEM; i++) begin
                elem_res[i] <= '0;
            end
            scalar_res <= '0;
        end else begin
            if (res_wr.elem_we)
                elem_res[res_wr.idx] <= res_wr.value;
            if (res_wr.scalar_we)
                scalar_res <= res_wr.value;
        end
    end

    // bus-side read, no latency
    assign rd_data = rd_scalar_sel ? scalar_res : elem_res[rd_idx];

endmodule

// ==== logic/vec_top.sv ====
module vec_top import vec_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [ADDR_W-1:0]   awaddr,
    input  logic                awvalid,
    output logic                awready,
    input  logic [DATA_W-1:0]   wdata,
    input  logic [DATA_W/8-1:0] wstrb,
    input  logic                wvalid,
    output logic                wready,
    output logic [1:0]          bresp,
    output logic                bvalid,
    input  logic                bready,
    input  logic [ADDR_W-1:0]   araddr,
    input  logic                arvalid,
    output logic                arready,
    output logic [DATA_W-1:0]   rdata,
    output logic [1:0]          rresp,
    output logic                rvalid,
    input  logic                rready
);

    bank_wr_t         bank_wr;          // regs -> bank
    logic             start;            // ctrl write pulse
    vec_op_e          op;
    logic             busy;
    logic             done;
    logic [IDX_W-1:0] res_idx;
    logic             res_scalar_sel;
    logic [RES_W-1:0] res_rdata;
    lane_t            issue;            // ctrl -> core
    logic [IDX_W-1:0] rd_idx;           // ctrl -> bank
    operand_t         operands;         // bank -> core
    logic             acc_clear;
    res_wr_t          res_wr;           // core -> result mem
    logic             wb_last;

    vec_regs regs_block (
        .clk(clk), .rst_n(rst_n),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .bank_wr(bank_wr), .start(start), .op(op), .busy(busy), .done(done),
        .res_idx(res_idx), .res_scalar_sel(res_scalar_sel), .res_rdata(res_rdata)
    );

    vec_bank operand_bank (
        .clk(clk), .rst_n(rst_n),
        .bank_wr(bank_wr), .rd_idx(rd_idx), .rd_data(operands)
    );

    vec_ctrl ctrl_unit (
        .clk(clk), .rst_n(rst_n),
        .start(start), .op(op), .issue(issue), .rd_idx(rd_idx),
        .acc_clear(acc_clear), .wb_last(wb_last), .busy(busy), .done(done)
    );

    vec_core processing_core (
        .clk(clk), .rst_n(rst_n),
        .issue(issue), .operands(operands), .acc_clear(acc_clear),
        .res_wr(res_wr), .wb_last(wb_last)
    );

    vec_result_mem result_mem (
        .clk(clk), .rst_n(rst_n),
        .res_wr(res_wr), .rd_idx(res_idx),
        .rd_scalar_sel(res_scalar_sel), .rd_data(res_rdata)
    );

endmodule

// ==== sim/tb_vec_axi.svh ====
`ifndef TB_VEC_AXI_SVH
`define TB_VEC_AXI_SVH

// single AXI4-Lite write, entered at the drive point just after a rising edge
task automatic axi_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                         output logic [1:0] resp);
    awaddr  = addr;
    wdata   = data;
    wstrb   = '1;
    awvalid = 1'b1;                          // aw and w presented together
    wvalid  = 1'b1;
    @(negedge clk);
    while (!(awready && wready)) @(negedge clk);   // ready seen mid-cycle
    @(posedge clk);                          // transfer edge
    #5;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    @(negedge clk);
    while (!bvalid) @(negedge clk);
    resp = bresp;
    @(posedge clk);                          // bvalid waits one edge for bready
    #5;
    bready = 1'b1;
    @(posedge clk);                          // response taken here
    #5;
    bready = 1'b0;
endtask

// single AXI4-Lite read, same entry point as the write
task automatic axi_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
                        output logic [1:0] resp);
    araddr  = addr;
    arvalid = 1'b1;
    @(negedge clk);
    while (!arready) @(negedge clk);
    @(posedge clk);
    #5;
    arvalid = 1'b0;
    @(negedge clk);
    while (!rvalid) @(negedge clk);
    data = rdata;                            // stable while rvalid waits
    resp = rresp;
    @(posedge clk);                          // rvalid waits one edge for rready
    #5;
    rready = 1'b1;
    @(posedge clk);
    #5;
    rready = 1'b0;
endtask

`endif

// ==== sim/tb_vec_top.sv ====
module tb_vec_top import vec_pkg::*; ();

    localparam int CLK_PERIOD = 40;
    localparam int NUM_TESTS  = 6;
    localparam int MAX_POLLS  = 100;          // status reads before giving up on a run
    localparam logic [31:0] SEED = 32'h752ea4c2;

    logic                clk;
    logic                rst_n;
    logic [ADDR_W-1:0]   awaddr;
    logic                awvalid;
    logic                awready;
    logic [DATA_W-1:0]   wdata;
    logic [DATA_W/8-1:0] wstrb;
    logic                wvalid;
    logic                wready;
    logic [1:0]          bresp;
    logic                bvalid;
    logic                bready;
    logic [ADDR_W-1:0]   araddr;
    logic                arvalid;
    logic                arready;
    logic [DATA_W-1:0]   rdata;
    logic [1:0]          rresp;
    logic                rvalid;
    logic                rready;

    int          errors;                      // every failed check, bus rules too
    int          base_errors;                 // count when the current test began
    int          test_num;
    int          tests_failed;
    int unsigned a_val [NUM_ELEM];            // model copy of A
    int unsigned b_val [NUM_ELEM];            // model copy of B

    vec_top i_vec_top (.*);

    `include "tb_vec_axi.svh"

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // valid from the DUT holds, with its payload, until the host is ready
    assert property (@(posedge clk) disable iff (!rst_n)
        (bvalid && !bready) |=> (bvalid && $stable(bresp)))
    else begin
        $display("bvalid or bresp changed before bready was given");
        errors++;
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        (rvalid && !rready) |=> (rvalid && $stable(rdata) && $stable(rresp)))
    else begin
        $display("rvalid or read data changed before rready was given");
        errors++;
    end

    // one reset edge is enough to clear handshakes, run state and the core lanes
    assert property (@(posedge clk) !rst_n |=> !(awready || wready || bvalid || arready
        || rvalid || i_vec_top.busy || i_vec_top.done || i_vec_top.issue.valid
        || i_vec_top.processing_core.s1_lane.valid
        || i_vec_top.processing_core.s2_lane.valid))
    else begin
        $display("a handshake, busy, done or lane valid is high during reset");
        errors++;
    end

    function automatic logic [ADDR_W-1:0] elem_addr(input logic [ADDR_W-1:0] base, input int i);
        return base + ADDR_W'(4 * i);         // one word per element
    endfunction

    // element rules for read, sum and avg
    function automatic logic [RES_W-1:0] expect_elem(input vec_op_e op, input int unsigned a,
                                                     input int unsigned b);
        case (op)
            OP_SUM:  return a + b;
            OP_AVG:  return (a + b) / 2;      // rounds down
            default: return a;
        endcase
    endfunction

    // man or dot over the model operands
    function automatic logic [RES_W-1:0] expect_scalar(input vec_op_e op);
        int unsigned total;
        total = 0;
        for (int i = 0; i < NUM_ELEM; i++) begin
            if (op == OP_MAN)
                total += (a_val[i] > b_val[i]) ? a_val[i] - b_val[i] : b_val[i] - a_val[i];
            else
                total += a_val[i] * b_val[i];
        end
        return total;
    endfunction

    task automatic check_val(input string name, input logic [DATA_W-1:0] expected,
                             input logic [DATA_W-1:0] actual);
        assert (actual === expected)
        else begin
            $display("FAIL %s expected %h got %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_resp(input string name, input logic [1:0] expected,
                              input logic [1:0] actual);
        assert (actual === expected)
        else begin
            $display("FAIL %s expected %h got %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic write_checked(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        logic [1:0] resp;
        axi_write(addr, data, resp);
        check_resp($sformatf("bresp @%h", addr), RESP_OKAY, resp);
    endtask

    task automatic read_checked(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
        logic [1:0] resp;
        axi_read(addr, data, resp);
        check_resp($sformatf("rresp @%h", addr), RESP_OKAY, resp);
    endtask

    // full random words so the dropped upper bits get exercised
    task automatic load_operands(input bit all_max);
        logic [DATA_W-1:0] word;
        for (int i = 0; i < NUM_ELEM; i++) begin
            word = all_max ? DATA_W'(1023) : $urandom;
            write_checked(elem_addr(BASE_A, i), word);
            a_val[i] = word & 32'h3ff;
            word = all_max ? DATA_W'(1023) : $urandom;
            write_checked(elem_addr(BASE_B, i), word);
            b_val[i] = word & 32'h3ff;
        end
    endtask

    task automatic readback_operands();
        logic [DATA_W-1:0] rd;
        for (int i = 0; i < NUM_ELEM; i++) begin
            read_checked(elem_addr(BASE_A, i), rd);
            check_val($sformatf("rdata A[%0d]", i), a_val[i], rd);
            read_checked(elem_addr(BASE_B, i), rd);
            check_val($sformatf("rdata B[%0d]", i), b_val[i], rd);
        end
    endtask

    task automatic wait_done();
        logic [DATA_W-1:0] status;
        int polls;
        polls  = 0;
        status = '0;
        while (!status[1] && polls < MAX_POLLS) begin
            read_checked(REG_STATUS, status);
            polls++;
        end
        if (!status[1]) begin
            $display("run never reported done after %0d status polls", polls);
            errors++;
        end
    endtask

    task automatic run_op(input vec_op_e op);
        write_checked(REG_CTRL, DATA_W'(op));
        wait_done();
    endtask

    task automatic check_elems(input vec_op_e op);
        logic [DATA_W-1:0] rd;
        for (int i = 0; i < NUM_ELEM; i++) begin
            read_checked(elem_addr(BASE_RES, i), rd);
            check_val($sformatf("rdata %s res[%0d]", op.name(), i),
                      expect_elem(op, a_val[i], b_val[i]), rd);
        end
    endtask

    task automatic check_scalar(input vec_op_e op);
        logic [DATA_W-1:0] rd;
        read_checked(REG_SCALAR, rd);
        check_val($sformatf("rdata %s scalar", op.name()), expect_scalar(op), rd);
    endtask

    task automatic end_test(input string name);
        test_num++;
        if (errors == base_errors) begin
            $display("test %0d %s: ok", test_num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", test_num, name, errors - base_errors);
        end
        base_errors = errors;
    endtask

    initial begin
        logic [DATA_W-1:0] rd;
        logic [1:0]        resp;
        void'($urandom(SEED));
        rst_n   = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        errors       = 0;
        base_errors  = 0;
        test_num     = 0;
        tests_failed = 0;
        repeat (3) @(posedge clk);
        #5;
        rst_n = 1'b1;

        check_val("bvalid", '0, DATA_W'(bvalid));
        check_val("rvalid", '0, DATA_W'(rvalid));
        read_checked(REG_STATUS, rd);
        check_val("rdata STATUS", '0, rd);       // idle, no done yet
        end_test("reset state");

        load_operands(1'b0);
        readback_operands();
        axi_write(8'h20, 32'hdeadbeef, resp);    // hole between status and A
        check_resp("bresp unmapped", RESP_SLVERR, resp);
        axi_read(8'h20, rd, resp);
        check_resp("rresp unmapped", RESP_SLVERR, resp);
        check_val("rdata unmapped", '0, rd);
        end_test("operand readback");

        load_operands(1'b0);
        run_op(OP_READ);
        check_elems(OP_READ);
        run_op(OP_SUM);
        check_elems(OP_SUM);
        run_op(OP_AVG);
        check_elems(OP_AVG);
        end_test("element ops");

        run_op(OP_MAN);
        check_scalar(OP_MAN);
        run_op(OP_DOT);
        check_scalar(OP_DOT);
        load_operands(1'b1);                     // largest operands, widest dot
        run_op(OP_MAN);
        check_scalar(OP_MAN);
        run_op(OP_DOT);
        check_scalar(OP_DOT);
        end_test("scalar ops");

        load_operands(1'b0);
        write_checked(REG_CTRL, DATA_W'(OP_SUM));
        write_checked(elem_addr(BASE_A, 0), a_val[0] ^ 32'h155);  // lands while busy
        write_checked(REG_CTRL, DATA_W'(OP_READ));                // second start, ignored
        wait_done();
        check_elems(OP_SUM);
        readback_operands();                     // model keeps the old A[0]
        end_test("writes while busy");

        read_checked(REG_STATUS, rd);
        check_val("rdata STATUS", 32'h2, rd);    // done from the last run
        write_checked(REG_CTRL, DATA_W'(OP_AVG));
        read_checked(REG_STATUS, rd);
        check_val("rdata STATUS", 32'h1, rd);    // busy, done cleared
        wait_done();
        read_checked(REG_STATUS, rd);
        check_val("rdata STATUS", 32'h2, rd);
        check_elems(OP_AVG);
        end_test("done restart");

        $display("%0d tests run, %0d failed, %0d errors", test_num, tests_failed, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // budget of 2000 cycles per test
    initial begin
        #(NUM_TESTS * 2000 * CLK_PERIOD);
        $display("timeout after %0d cycles, the run is stuck", NUM_TESTS * 2000);
        $display("sim failed");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+sim
logic/vec_pkg.sv
logic/vec_bank.sv
logic/vec_regs.sv
logic/vec_ctrl.sv
logic/vec_core.sv
logic/vec_result_mem.sv
logic/vec_top.sv
sim/tb_vec_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_vec_top
FILELIST  ?= sim.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "^sim passed$$"

clean:
	rm -rf obj_dir
